/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_decode_stage
FILELIST  ?= decode_stage.f
BIN       := obj_dir/V$(TOP)
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* common/cpu_pkg.sv */
// cpu package
// word and register types, opcode, alu function and flag mode encodings for decode
package cpu_pkg;

  localparam int WORD_W     = 16;                // data, instr and pc width
  localparam int NUM_REGS   = 16;                // register file depth
  localparam int REG_ADDR_W = $clog2(NUM_REGS);  // 4 bit register index
  localparam int IMM_W      = 8;                 // immediate field
  localparam int JOFF_W     = 12;                // jump offset field
  localparam int SHAMT_W    = 4;                 // shift amount
  localparam int BR_OP_W    = 3;                 // branch condition code

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // top nibble of the instruction
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_ADDZ = 4'h1,  // add, writes only when zero flag set
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_NOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_SRA  = 4'h7,
    OP_LW   = 4'h8,
    OP_SW   = 4'h9,
    OP_LHB  = 4'ha,
    OP_LLB  = 4'hb,
    OP_B    = 4'hc,
    OP_JAL  = 4'hd,
    OP_JR   = 4'he,
    OP_HLT  = 4'hf
  } opcode_t;

  // function code handed to the execute alu
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_NOR = 3'd3,
    ALU_SLL = 3'd4,
    ALU_SRL = 3'd5,
    ALU_SRA = 3'd6,
    ALU_LHB = 3'd7
  } alu_func_t;

  // which flags execute updates
  typedef enum logic [1:0] {
    FLAGS_NONE        = 2'd0,
    FLAGS_ZERO_ONLY   = 2'd1,  // zero flag only
    FLAGS_ALL         = 2'd2,
    FLAGS_ALL_IF_ZERO = 2'd3   // addz
  } flag_mode_t;

  localparam reg_addr_t LINK_REG = reg_addr_t'(NUM_REGS - 1);  // jal writes r15

endpackage

/* decode/id_ex_pipe.sv */
`timescale 1ns/1ns
// id/ex pipeline register
// holds on stall, loads a bubble on flush, flush has priority
module id_ex_pipe (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        stall,
  input  logic                        flush,
  input  cpu_pkg::word_t              pc,
  input  cpu_pkg::word_t              p0_data,
  input  cpu_pkg::word_t              p1_data,
  input  cpu_pkg::reg_addr_t          p0_addr,
  input  cpu_pkg::reg_addr_t          p1_addr,
  input  cpu_pkg::reg_addr_t          reg_write_addr,
  input  logic [cpu_pkg::IMM_W-1:0]   immediate,
  input  logic [cpu_pkg::JOFF_W-1:0]  jump_offset,
  input  logic [cpu_pkg::SHAMT_W-1:0] shamt,
  input  cpu_pkg::alu_func_t          alu_op,
  input  logic [cpu_pkg::BR_OP_W-1:0] branch_op,
  input  cpu_pkg::flag_mode_t         flag_set,
  input  logic                        alu_src, mem_write, mem_read, mem_to_reg, reg_write,
  input  logic                        pc_src, branch_instr, jump_from_reg, hlt,
  output cpu_pkg::word_t              ex_pc,
  output cpu_pkg::word_t              ex_p0_data,
  output cpu_pkg::word_t              ex_p1_data,
  output cpu_pkg::reg_addr_t          ex_p0_addr,
  output cpu_pkg::reg_addr_t          ex_p1_addr,
  output cpu_pkg::reg_addr_t          ex_reg_write_addr,
  output logic [cpu_pkg::IMM_W-1:0]   ex_immediate,
  output logic [cpu_pkg::JOFF_W-1:0]  ex_jump_offset,
  output logic [cpu_pkg::SHAMT_W-1:0] ex_shamt,
  output cpu_pkg::alu_func_t          ex_alu_op,
  output logic [cpu_pkg::BR_OP_W-1:0] ex_branch_op,
  output cpu_pkg::flag_mode_t         ex_flag_set,
  output logic                        ex_alu_src, ex_mem_write, ex_mem_read, ex_mem_to_reg,
  output logic                        ex_reg_write, ex_pc_src, ex_branch_instr,
  output logic                        ex_jump_from_reg, ex_hlt
);
  import cpu_pkg::*;

  logic load;  // payload capture enable

  assign load = flush || !stall;

  // controls, a bubble is a nop that writes nothing and touches no flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_alu_op        <= ALU_ADD;
      ex_flag_set      <= FLAGS_NONE;
      ex_branch_op     <= '0;
      ex_alu_src       <= 1'b0;
      ex_mem_write     <= 1'b0;
      ex_mem_read      <= 1'b0;
      ex_mem_to_reg    <= 1'b0;
      ex_reg_write     <= 1'b0;
      ex_pc_src        <= 1'b0;
      ex_branch_instr  <= 1'b0;
      ex_jump_from_reg <= 1'b0;
      ex_hlt           <= 1'b0;
    end else if (flush) begin
      ex_alu_op        <= ALU_ADD;
      ex_flag_set      <= FLAGS_NONE;
      ex_branch_op     <= '0;
      ex_alu_src       <= 1'b0;
      ex_mem_write     <= 1'b0;
      ex_mem_read      <= 1'b0;
      ex_mem_to_reg    <= 1'b0;
      ex_reg_write     <= 1'b0;
      ex_pc_src        <= 1'b0;
      ex_branch_instr  <= 1'b0;
      ex_jump_from_reg <= 1'b0;
      ex_hlt           <= 1'b0;
    end else if (!stall) begin
      ex_alu_op        <= alu_op;
      ex_flag_set      <= flag_set;
      ex_branch_op     <= branch_op;
      ex_alu_src       <= alu_src;
      ex_mem_write     <= mem_write;
      ex_mem_read      <= mem_read;
      ex_mem_to_reg    <= mem_to_reg;
      ex_reg_write     <= reg_write;
      ex_pc_src        <= pc_src;
      ex_branch_instr  <= branch_instr;
      ex_jump_from_reg <= jump_from_reg;
      ex_hlt           <= hlt;
    end
  end

  // operands, addresses and fields, meaningless under a bubble
  always_ff @(posedge clk) begin
    if (load) begin
      ex_pc             <= pc;
      ex_p0_data        <= p0_data;
      ex_p1_data        <= p1_data;
      ex_p0_addr        <= p0_addr;        // for forwarding
      ex_p1_addr        <= p1_addr;
      ex_reg_write_addr <= reg_write_addr;
      ex_immediate      <= immediate;
      ex_jump_offset    <= jump_offset;
      ex_shamt          <= shamt;
    end
  end

endmodule

/* decode/instr_decode.sv */
`timescale 1ns/1ns
// instruction decoder
// splits the instruction into register addresses, immediates and controls, owns the rf
module instr_decode (
  input  logic                          clk,
  input  logic                          rst_n,
  input  cpu_pkg::word_t                instr,
  input  logic                          wb_reg_write,
  input  cpu_pkg::reg_addr_t            wb_reg_addr,
  input  cpu_pkg::word_t                wb_data,
  output cpu_pkg::word_t                p0_data,
  output cpu_pkg::word_t                p1_data,
  output cpu_pkg::reg_addr_t            p0_addr,
  output cpu_pkg::reg_addr_t            p1_addr,
  output cpu_pkg::reg_addr_t            reg_write_addr,
  output logic [cpu_pkg::IMM_W-1:0]     immediate,
  output logic [cpu_pkg::JOFF_W-1:0]    jump_offset,
  output logic [cpu_pkg::SHAMT_W-1:0]   shamt,
  output cpu_pkg::alu_func_t            alu_op,
  output logic [cpu_pkg::BR_OP_W-1:0]   branch_op,
  output cpu_pkg::flag_mode_t           flag_set,
  output logic                          alu_src,
  output logic                          mem_write,
  output logic                          mem_read,
  output logic                          mem_to_reg,
  output logic                          reg_write,
  output logic                          pc_src,
  output logic                          branch_instr,
  output logic                          jump_from_reg,
  output logic                          hlt
);
  import cpu_pkg::*;

  opcode_t opcode;
  logic    re0;  // rf port 0 enable
  logic    re1;  // rf port 1 enable

  assign opcode = opcode_t'(instr[15:12]);

  reg_file u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .p0_addr  (p0_addr),
    .p1_addr  (p1_addr),
    .re0      (re0),
    .re1      (re1),
    .dst_addr (wb_reg_addr),   // write port straight from writeback
    .dst      (wb_data),
    .we       (wb_reg_write),
    .p0       (p0_data),
    .p1       (p1_data)
  );

  always_comb begin
    p0_addr        = instr[7:4];   // rs
    p1_addr        = instr[3:0];   // rt
    reg_write_addr = instr[11:8];  // rd
    re0            = 1'b1;
    re1            = 1'b1;
    reg_write      = 1'b1;
    immediate      = instr[7:0];
    jump_offset    = instr[11:0];
    shamt          = instr[3:0];
    branch_op      = instr[11:9];  // branch condition
    alu_op         = ALU_ADD;
    flag_set       = FLAGS_ALL;
    alu_src        = 1'b0;         // 1 selects immediate as alu b
    mem_write      = 1'b0;
    mem_read       = 1'b0;
    mem_to_reg     = 1'b0;
    pc_src         = 1'b0;
    branch_instr   = 1'b0;
    jump_from_reg  = 1'b0;
    hlt            = 1'b0;

    if (instr[15]) flag_set = FLAGS_NONE;  // lw onward leave flags alone

    case (opcode)
      OP_ADD:  ;                                  // defaults
      OP_ADDZ: flag_set = FLAGS_ALL_IF_ZERO;
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND: begin
        alu_op   = ALU_AND;
        flag_set = FLAGS_ZERO_ONLY;
      end
      OP_NOR: begin
        alu_op   = ALU_NOR;
        flag_set = FLAGS_ZERO_ONLY;
      end
      OP_SLL: begin
        alu_op   = ALU_SLL;
        flag_set = FLAGS_ZERO_ONLY;
      end
      OP_SRL: begin
        re1      = 1'b0;                          // shamt comes from instr
        alu_op   = ALU_SRL;
        flag_set = FLAGS_ZERO_ONLY;
      end
      OP_SRA: begin
        re1      = 1'b0;
        alu_op   = ALU_SRA;
        flag_set = FLAGS_ZERO_ONLY;
      end
      OP_LW: begin
        re1        = 1'b0;
        mem_read   = 1'b1;
        mem_to_reg = 1'b1;
        alu_src    = 1'b1;                        // base + offset
        immediate  = {{(IMM_W-4){instr[3]}}, instr[3:0]};
      end
      OP_SW: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        reg_write = 1'b0;
        p1_addr   = instr[11:8];                  // store data reg
        immediate = {{(IMM_W-4){instr[3]}}, instr[3:0]};
      end
      OP_LHB: begin
        re1     = 1'b0;
        p0_addr = instr[11:8];                    // keep low byte of rd
        alu_op  = ALU_LHB;
        alu_src = 1'b1;
      end
      OP_LLB: begin
        re1     = 1'b0;
        p0_addr = '0;                             // r0 + imm
        alu_src = 1'b1;
      end
      OP_B: begin
        re0          = 1'b0;
        re1          = 1'b0;
        pc_src       = 1'b1;
        branch_instr = 1'b1;
        alu_src      = 1'b1;
        reg_write    = 1'b0;
        jump_offset  = {{(JOFF_W-9){instr[8]}}, instr[8:0]};
      end
      OP_JAL: begin
        re0            = 1'b0;
        re1            = 1'b0;
        alu_src        = 1'b1;
        reg_write_addr = LINK_REG;                // return address to r15
      end
      OP_JR: begin
        re1           = 1'b0;
        pc_src        = 1'b1;
        jump_from_reg = 1'b1;                     // target is rs
        reg_write     = 1'b0;
      end
      OP_HLT: begin
        re0       = 1'b0;
        re1       = 1'b0;
        reg_write = 1'b0;
        hlt       = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* decode_stage.f */
common/cpu_pkg.sv
design/reg_file.sv
decode/instr_decode.sv
decode/id_ex_pipe.sv
design/decode_stage.sv
tb/tb_clock.sv
tb/decode_checker.sv
tb/tb_decode_stage.sv

/* design/decode_stage.sv */
`timescale 1ns/1ns
// decode stage top
// decoder with register file feeding the id/ex register
module decode_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  cpu_pkg::word_t              instr,
  input  cpu_pkg::word_t              pc,
  input  logic                        stall,          // hazard unit hold
  input  logic                        flush,          // hazard unit kill
  input  logic                        wb_reg_write,
  input  cpu_pkg::reg_addr_t          wb_reg_addr,
  input  cpu_pkg::word_t              wb_data,
  output cpu_pkg::word_t              ex_pc,
  output cpu_pkg::word_t              ex_p0_data,
  output cpu_pkg::word_t              ex_p1_data,
  output cpu_pkg::reg_addr_t          ex_p0_addr,
  output cpu_pkg::reg_addr_t          ex_p1_addr,
  output cpu_pkg::reg_addr_t          ex_reg_write_addr,
  output logic [cpu_pkg::IMM_W-1:0]   ex_immediate,
  output logic [cpu_pkg::JOFF_W-1:0]  ex_jump_offset,
  output logic [cpu_pkg::SHAMT_W-1:0] ex_shamt,
  output cpu_pkg::alu_func_t          ex_alu_op,
  output logic [cpu_pkg::BR_OP_W-1:0] ex_branch_op,
  output cpu_pkg::flag_mode_t         ex_flag_set,
  output logic                        ex_alu_src, ex_mem_write, ex_mem_read, ex_mem_to_reg,
  output logic                        ex_reg_write, ex_pc_src, ex_branch_instr,
  output logic                        ex_jump_from_reg, ex_hlt
);
  import cpu_pkg::*;

  // decoder outputs, combinational into the pipe register
  word_t              p0_data;
  word_t              p1_data;
  reg_addr_t          p0_addr;
  reg_addr_t          p1_addr;
  reg_addr_t          reg_write_addr;
  logic [IMM_W-1:0]   immediate;
  logic [JOFF_W-1:0]  jump_offset;
  logic [SHAMT_W-1:0] shamt;
  alu_func_t          alu_op;
  logic [BR_OP_W-1:0] branch_op;
  flag_mode_t         flag_set;
  logic               alu_src, mem_write, mem_read, mem_to_reg, reg_write;
  logic               pc_src, branch_instr, jump_from_reg, hlt;

  instr_decode u_decode (.*);  // names match the wires above

  id_ex_pipe u_id_ex (.*);     // ex_ outputs go straight to the ports

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ns
// register file
// sixteen words, r0 reads zero, two read ports with write-through and hold on disable
module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::reg_addr_t p0_addr,
  input  cpu_pkg::reg_addr_t p1_addr,
  input  logic               re0,
  input  logic               re1,
  input  cpu_pkg::reg_addr_t dst_addr,
  input  cpu_pkg::word_t     dst,
  input  logic               we,
  output cpu_pkg::word_t     p0,
  output cpu_pkg::word_t     p1
);
  import cpu_pkg::*;

  word_t regs [NUM_REGS];  // r0 never written so stays zero
  word_t p0_rd;            // port 0 read incl bypass
  word_t p1_rd;
  word_t p0_hold;          // last value port 0 returned
  word_t p1_hold;
  logic  wr_en;

  assign wr_en = we && (dst_addr != '0);  // writes to r0 dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[dst_addr] <= dst;
    end
  end

  // same-cycle write wins over array contents
  assign p0_rd = (wr_en && (dst_addr == p0_addr)) ? dst : regs[p0_addr];
  assign p1_rd = (wr_en && (dst_addr == p1_addr)) ? dst : regs[p1_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p0_hold <= '0;
      p1_hold <= '0;
    end else begin
      if (re0) p0_hold <= p0_rd;  // follow while enabled
      if (re1) p1_hold <= p1_rd;
    end
  end

  assign p0 = re0 ? p0_rd : p0_hold;  // disabled port repeats old value
  assign p1 = re1 ? p1_rd : p1_hold;

endmodule

/* tb/decode_cases.txt */
# kind instr pc stall flush wb_we wb_addr wb_data, then expected ex_pc p0_data p1_data p0_addr
# p1_addr wr_addr imm joff shamt alu_op br_op flag_set ctrl(alu_src..hlt), all in hex
reset  f000 0000 1 0 0 0 0000  0000 0000 0000 0 0 0 00 000 0 0 0 0 000
write  f000 0000 0 0 1 1 1111  0000 0000 0000 0 0 0 00 000 0 0 0 0 000
write  f000 0000 0 0 1 2 2222  0000 0000 0000 0 0 0 00 000 0 0 0 0 000
write  f000 0000 0 0 1 3 8003  0000 0000 0000 0 0 0 00 000 0 0 0 0 000
decode 0123 0010 0 0 0 0 0000  0010 2222 8003 2 3 1 23 123 3 0 0 2 010
decode 1412 0012 0 0 1 2 beef  0012 1111 beef 1 2 4 12 412 2 0 2 3 010
decode 2e21 0014 0 0 0 0 0000  0014 beef 1111 2 1 e 21 e21 1 1 7 2 010
decode 3a30 0016 0 0 0 0 0000  0016 8003 0000 3 0 a 30 a30 0 2 5 1 010
write  f000 0000 0 0 1 0 ffff  0000 0000 0000 0 0 0 00 000 0 0 0 0 000
decode 4601 0018 0 0 1 0 dead  0018 0000 1111 0 1 6 01 601 1 3 3 1 010
decode 5732 001a 0 0 0 0 0000  001a 8003 beef 3 2 7 32 732 2 4 3 1 010
decode 6814 001c 0 0 0 0 0000  001c 1111 beef 1 4 8 14 814 4 5 4 1 010
decode 7923 001e 0 0 0 0 0000  001e beef beef 2 3 9 23 923 3 6 4 1 010
decode 8b3c 0020 0 0 0 0 0000  0020 8003 beef 3 c b fc b3c c 0 5 0 170
decode 9217 0022 0 0 0 0 0000  0022 1111 beef 1 2 2 07 217 7 0 1 0 180
decode a1ab 0024 0 0 0 0 0000  0024 1111 beef 1 b 1 ab 1ab b 7 0 0 110
decode b3cd 0026 0 0 0 0 0000  0026 0000 beef 0 d 3 cd 3cd d 0 1 0 110
decode c5f0 0028 0 0 0 0 0000  0028 0000 beef f 0 5 f0 ff0 0 0 2 0 10c
decode d123 002a 0 0 0 0 0000  002a 0000 beef 2 3 f 23 123 3 0 0 0 110
decode e010 002c 0 0 0 0 0000  002c 1111 beef 1 0 0 10 010 0 0 0 0 00a
decode f7e5 002e 0 0 0 0 0000  002e 1111 beef e 5 7 e5 7e5 5 0 3 0 001
stall  f000 0030 1 0 0 0 0000  002e 1111 beef e 5 7 e5 7e5 5 0 3 0 001
decode 0213 0032 0 0 0 0 0000  0032 1111 8003 1 3 2 13 213 3 0 1 2 010
flush  f000 0034 0 1 0 0 0000  0000 0000 0000 0 0 0 00 000 0 0 0 0 000
decode 2123 0036 0 0 0 0 0000  0036 beef 8003 2 3 1 23 123 3 1 0 2 010
flush  f000 0038 1 1 0 0 0000  0000 0000 0000 0 0 0 00 000 0 0 0 0 000

/* tb/decode_checker.sv */
`timescale 1ns/1ns
// decode stage checker
// compares the ex_ outputs with the expected values one rising edge after capture
module decode_checker (
  input  logic                        clk,
  input  logic                        exp_valid,      // a test was driven this cycle
  input  logic                        exp_full,       // payload fields are compared too
  input  int                          exp_id,
  input  logic [15:0]                 exp_vals [13],
  input  cpu_pkg::word_t              ex_pc,
  input  cpu_pkg::word_t              ex_p0_data,
  input  cpu_pkg::word_t              ex_p1_data,
  input  cpu_pkg::reg_addr_t          ex_p0_addr,
  input  cpu_pkg::reg_addr_t          ex_p1_addr,
  input  cpu_pkg::reg_addr_t          ex_reg_write_addr,
  input  logic [cpu_pkg::IMM_W-1:0]   ex_immediate,
  input  logic [cpu_pkg::JOFF_W-1:0]  ex_jump_offset,
  input  logic [cpu_pkg::SHAMT_W-1:0] ex_shamt,
  input  cpu_pkg::alu_func_t          ex_alu_op,
  input  logic [cpu_pkg::BR_OP_W-1:0] ex_branch_op,
  input  cpu_pkg::flag_mode_t         ex_flag_set,
  input  logic                        ex_alu_src, ex_mem_write, ex_mem_read, ex_mem_to_reg,
  input  logic                        ex_reg_write, ex_pc_src, ex_branch_instr,
  input  logic                        ex_jump_from_reg, ex_hlt,
  output int                          n_pass,
  output int                          n_fail
);
  import cpu_pkg::*;

  localparam int N_FIELDS   = 13;
  localparam int FIRST_CTRL = 9;    // fields from here on hold a bubble after reset and flush
  localparam int CTRL_FIELD = N_FIELDS - 1;  // single-bit controls packed together
  localparam int N_CTRL     = 9;

  string       names [N_FIELDS-1] = '{"ex_pc", "ex_p0_data", "ex_p1_data", "ex_p0_addr",
                                      "ex_p1_addr", "ex_reg_write_addr", "ex_immediate",
                                      "ex_jump_offset", "ex_shamt", "ex_alu_op",
                                      "ex_branch_op", "ex_flag_set"};
  // msb first, alu_src down to hlt
  string       ctrl_names [N_CTRL] = '{"ex_alu_src", "ex_mem_write", "ex_mem_read",
                                       "ex_mem_to_reg", "ex_reg_write", "ex_pc_src",
                                       "ex_branch_instr", "ex_jump_from_reg", "ex_hlt"};
  logic [15:0] act [N_FIELDS];      // dut outputs, zero extended
  logic [15:0] chk_exp [N_FIELDS];  // expectation for the edge under check
  logic        chk_valid = 1'b0;
  logic        chk_full  = 1'b0;
  int          chk_id    = 0;
  int          passed    = 0;
  int          failed    = 0;
  logic        bad;

  assign act[0]  = ex_pc;
  assign act[1]  = ex_p0_data;
  assign act[2]  = ex_p1_data;
  assign act[3]  = {12'b0, ex_p0_addr};
  assign act[4]  = {12'b0, ex_p1_addr};
  assign act[5]  = {12'b0, ex_reg_write_addr};
  assign act[6]  = {8'b0, ex_immediate};
  assign act[7]  = {4'b0, ex_jump_offset};
  assign act[8]  = {12'b0, ex_shamt};
  assign act[9]  = {13'b0, ex_alu_op};
  assign act[10] = {13'b0, ex_branch_op};
  assign act[11] = {14'b0, ex_flag_set};
  // alu_src in bit 8 down to hlt in bit 0
  assign act[12] = {7'b0, ex_alu_src, ex_mem_write, ex_mem_read, ex_mem_to_reg,
                    ex_reg_write, ex_pc_src, ex_branch_instr, ex_jump_from_reg, ex_hlt};

  assign n_pass = passed;
  assign n_fail = failed;

  // outputs seen here were loaded on the previous edge
  always @(posedge clk) begin
    if (chk_valid) begin
      bad = 1'b0;
      for (int i = 0; i < N_FIELDS; i++) begin
        if ((chk_full || i >= FIRST_CTRL) && act[i] !== chk_exp[i]) begin
          if (i == CTRL_FIELD) begin
            for (int b = 0; b < N_CTRL; b++) begin
              if (act[i][N_CTRL-1-b] !== chk_exp[i][N_CTRL-1-b]) begin
                $display("error %s expected %h got %h", ctrl_names[b],
                         chk_exp[i][N_CTRL-1-b], act[i][N_CTRL-1-b]);
              end
            end
          end else begin
            $display("error %s expected %h got %h", names[i], chk_exp[i], act[i]);
          end
          bad = 1'b1;
        end
      end
      if (bad) begin
        failed++;
        $display("test %0d failed", chk_id);
      end else begin
        passed++;
        $display("test %0d passed", chk_id);
      end
    end
    chk_valid = exp_valid;          // the dut captures this test on the current edge
    chk_full  = exp_full;
    chk_id    = exp_id;
    chk_exp   = exp_vals;
  end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ns
// testbench clock and reset
// 8 ns clock, rst_n held low for the first three cycles
module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;           // release away from the capture edge
  end

endmodule

/* tb/tb_decode_stage.sv */
`timescale 1ns/1ns
// decode stage testbench
// reads the cases file, drives one line per falling edge and reports the totals
module tb_decode_stage;
  import cpu_pkg::*;

  localparam int MAX_WAIT = 200;  // cycles allowed for any wait

  logic               clk, rst_n;
  word_t              instr, pc, wb_data;
  logic               stall, flush, wb_reg_write;
  reg_addr_t          wb_reg_addr;
  word_t              ex_pc, ex_p0_data, ex_p1_data;
  reg_addr_t          ex_p0_addr, ex_p1_addr, ex_reg_write_addr;
  logic [IMM_W-1:0]   ex_immediate;
  logic [JOFF_W-1:0]  ex_jump_offset;
  logic [SHAMT_W-1:0] ex_shamt;
  alu_func_t          ex_alu_op;
  logic [BR_OP_W-1:0] ex_branch_op;
  flag_mode_t         ex_flag_set;
  logic               ex_alu_src, ex_mem_write, ex_mem_read, ex_mem_to_reg;
  logic               ex_reg_write, ex_pc_src, ex_branch_instr, ex_jump_from_reg, ex_hlt;
  logic [15:0]        exp_vals [13];
  logic               exp_valid, exp_full;
  int                 exp_id;
  int                 n_pass, n_fail;

  tb_clock u_clock (.*);

  decode_stage UUT (.*);

  decode_checker u_check (.*);

  function automatic bit is_known_kind(string k);
    return (k == "reset") || (k == "write") || (k == "decode") ||
           (k == "stall") || (k == "flush");
  endfunction

  initial begin
    int          fd;
    int          cnt;
    int          fields;
    int          issued;
    int          errors;
    string       line;
    string       kind;
    logic [15:0] v_instr, v_pc, v_st, v_fl, v_we, v_wa, v_wd;
    logic [15:0] e [13];

    instr        = 16'hf000;  // halt keeps both read ports idle
    pc           = '0;
    stall        = 1'b1;      // hold the reset bubble until the first line
    flush        = 1'b0;
    wb_reg_write = 1'b0;
    wb_reg_addr  = '0;
    wb_data      = '0;
    exp_valid    = 1'b0;
    exp_full     = 1'b0;
    exp_id       = 0;
    foreach (exp_vals[i]) begin
      exp_vals[i] = '0;
    end
    issued = 0;
    errors = 0;

    cnt = 0;
    while (rst_n !== 1'b1 && cnt < MAX_WAIT) begin
      @(posedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", MAX_WAIT);
      errors++;
    end

    fd = $fopen("tb/decode_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the cases file tb/decode_cases.txt");
      errors++;
    end else if (errors == 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or column notes
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         kind, v_instr, v_pc, v_st, v_fl, v_we, v_wa, v_wd,
                         e[0], e[1], e[2], e[3], e[4], e[5], e[6],
                         e[7], e[8], e[9], e[10], e[11], e[12]);
        if (fields != 21 || !is_known_kind(kind)) begin
          $display("cases file line not understood: %s", line);
          errors++;
        end else begin
          @(negedge clk);
          instr        = v_instr;
          pc           = v_pc;
          stall        = v_st[0];
          flush        = v_fl[0];
          wb_reg_write = v_we[0];
          wb_reg_addr  = v_wa[3:0];
          wb_data      = v_wd;
          exp_vals     = e;
          exp_valid    = (kind != "write");  // write lines only set up registers
          exp_full     = (kind == "decode") || (kind == "stall");
          exp_id       = issued + 1;
          if (exp_valid) issued++;
        end
      end
      $fclose(fd);
      @(negedge clk);
      exp_valid    = 1'b0;
      stall        = 1'b1;
      wb_reg_write = 1'b0;
      cnt = 0;
      while (n_pass + n_fail < issued && cnt < MAX_WAIT) begin
        @(negedge clk);
        cnt++;
      end
      if (n_pass + n_fail < issued) begin
        $display("only %0d of %0d tests were checked within %0d cycles",
                 n_pass + n_fail, issued, MAX_WAIT);
        errors++;
      end
    end

    $display("tests passed %0d failed %0d other problems %0d", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0 && issued > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
